// ==== hdl/uart_pkg.sv ====
package uart_pkg;

    // Line and clock configuration
    localparam int CLK_FREQ     = 7_372_800;
    localparam int BAUD_RATE    = 115200;
    localparam int OVERSAMPLING = 16;   // Samples per bit
    localparam int BAUD_DIVIDER = CLK_FREQ / (BAUD_RATE * OVERSAMPLING);  // Clocks per sample

    // Frame format
    localparam bit PARITY_EN  = 1'b1;
    localparam bit PARITY_ODD = 1'b0;   // 0 selects even parity

    // Receive FIFO, depth must be a power of two
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // Framer states
    typedef enum logic [2:0] {
        IDLE,
        START_BIT,
        DATA_BITS,
        PARITY_BIT,
        STOP_BIT
    } rx_state_e;

    // One received character with the flags of its own frame
    typedef struct packed {
        logic       frame_error;    // Stop bit sampled low
        logic       parity_error;
        logic [7:0] data;
    } rx_word_t;

endpackage

// ==== hdl/uart_baud_timer.sv ====
`timescale 1ns/1ps

module uart_baud_timer import uart_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic timer_start,
    input  logic timer_run,
    output logic bit_tick
);

    typedef logic [$clog2(BAUD_DIVIDER)-1:0] div_t;
    typedef logic [$clog2(OVERSAMPLING)-1:0] samp_t;

    div_t  div_cnt;     // Clocks within one oversample
    samp_t samp_cnt;    // Oversamples within one bit
    logic  div_wrap;
    logic  samp_wrap;

    assign div_wrap  = (int'(div_cnt) == BAUD_DIVIDER - 1);
    assign samp_wrap = (int'(samp_cnt) == OVERSAMPLING - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt  <= '0;
            samp_cnt <= '0;
            bit_tick <= 1'b0;
        end else if (timer_start) begin
            // Start half a bit in, so the first tick lands mid start bit
            div_cnt  <= '0;
            samp_cnt <= samp_t'(OVERSAMPLING / 2);
            bit_tick <= 1'b0;
        end else if (timer_run) begin
            bit_tick <= 1'b0;
            if (div_wrap) begin
                div_cnt <= '0;
                if (samp_wrap) begin
                    samp_cnt <= '0;
                    bit_tick <= 1'b1;   // Middle of the current bit
                end else begin
                    samp_cnt <= samp_cnt + 1'b1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end else begin
            div_cnt  <= '0;
            samp_cnt <= '0;
            bit_tick <= 1'b0;
        end
    end

endmodule

// ==== hdl/uart_rx_framer.sv ====
`timescale 1ns/1ps

module uart_rx_framer import uart_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     rx_serial,
    input  logic     bit_tick,
    output logic     timer_start,
    output logic     timer_run,
    output logic     rx_busy,
    output logic     frame_done,
    output rx_word_t frame_word
);

    logic [2:0] rx_sync;
    logic       rx_line;        // Synchronized serial line

    rx_state_e  state;
    rx_state_e  next_state;

    logic [7:0] shift_reg;
    logic [2:0] bit_cnt;
    logic       parity_bit;
    logic       parity_err;
    logic       frame_end;      // Stop tick or rejected start

    // Three flops against metastability, idle high out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_sync <= 3'b111;
        end else begin
            rx_sync <= {rx_sync[1:0], rx_serial};
        end
    end

    assign rx_line = rx_sync[2];

    assign timer_start = (state == IDLE) && !rx_line;
    assign timer_run   = (state != IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (!rx_line) begin
                    next_state = START_BIT;
                end
            end
            START_BIT: begin
                // Line back high at mid start bit means a glitch
                if (bit_tick) begin
                    next_state = rx_line ? IDLE : DATA_BITS;
                end
            end
            DATA_BITS: begin
                if (bit_tick && (bit_cnt == 3'd7)) begin
                    next_state = PARITY_EN ? PARITY_BIT : STOP_BIT;
                end
            end
            PARITY_BIT: begin
                if (bit_tick) begin
                    next_state = STOP_BIT;
                end
            end
            STOP_BIT: begin
                if (bit_tick) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else if (state == DATA_BITS) begin
            if (bit_tick) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            bit_cnt <= '0;
        end
    end

    // Data arrives LSB first, so shift in from the top
    always_ff @(posedge clk) begin
        if (bit_tick && (state == DATA_BITS)) begin
            shift_reg <= {rx_line, shift_reg[7:1]};
        end
        if (bit_tick && (state == PARITY_BIT)) begin
            parity_bit <= rx_line;
        end
    end

    // Even parity bit equals the XOR of the data
    assign parity_err = PARITY_EN && (parity_bit != ((^shift_reg) ^ PARITY_ODD));

    assign frame_end = bit_tick &&
                       ((state == STOP_BIT) || ((state == START_BIT) && rx_line));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_busy <= 1'b0;
        end else if (frame_end) begin
            rx_busy <= 1'b0;
        end else begin
            rx_busy <= (state != IDLE);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_done <= 1'b0;
        end else begin
            frame_done <= bit_tick && (state == STOP_BIT);
        end
    end

    // Word and flags are captured together at the stop tick
    always_ff @(posedge clk) begin
        if (bit_tick && (state == STOP_BIT)) begin
            frame_word.data         <= shift_reg;
            frame_word.frame_error  <= !rx_line;    // Stop bit must be high
            frame_word.parity_error <= parity_err;
        end
    end

endmodule

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo import uart_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr_en,
    input  rx_word_t wr_word,
    input  logic     rd_en,
    output rx_word_t rd_word,
    output logic     full,
    output logic     empty
);

    rx_word_t         mem [FIFO_DEPTH];

    // Extra top bit tells full from empty when the addresses match
    logic [FIFO_AW:0] wr_ptr;
    logic [FIFO_AW:0] rd_ptr;
    logic             do_wr;
    logic             do_rd;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                   (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

    assign do_rd = rd_en && !empty;
    assign do_wr = wr_en && (!full || do_rd);   // A read in the same cycle makes room

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= wr_word;
        end
    end

    // Head entry is visible without a read
    assign rd_word = mem[rd_ptr[FIFO_AW-1:0]];

endmodule

// ==== hdl/uart_receiver.sv ====
`timescale 1ns/1ps

module uart_receiver import uart_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     rx_serial,
    input  logic     rx_read,
    output rx_word_t rx_word,
    output logic     rx_valid,
    output logic     rx_busy,
    output logic     rx_overrun,
    output logic     fifo_full
);

    logic     timer_start;
    logic     timer_run;
    logic     bit_tick;
    logic     frame_done;
    rx_word_t frame_word;
    logic     fifo_wr;
    logic     fifo_empty;

    uart_rx_framer i_framer (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_serial  (rx_serial),
        .bit_tick   (bit_tick),
        .timer_start(timer_start),
        .timer_run  (timer_run),
        .rx_busy    (rx_busy),
        .frame_done (frame_done),
        .frame_word (frame_word)
    );

    uart_baud_timer i_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .timer_start(timer_start),
        .timer_run  (timer_run),
        .bit_tick   (bit_tick)
    );

    // A read while full frees a slot for the arriving frame
    assign fifo_wr    = frame_done && (!fifo_full || rx_read);
    assign rx_overrun = frame_done && fifo_full && !rx_read;   // Frame dropped

    sync_fifo i_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (fifo_wr),
        .wr_word(frame_word),
        .rd_en  (rx_read),
        .rd_word(rx_word),
        .full   (fifo_full),
        .empty  (fifo_empty)
    );

    assign rx_valid = !fifo_empty;

endmodule

// ==== tests/uart_receiver_chk.sv ====
`timescale 1ns/1ps

module uart_receiver_chk import uart_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input rx_word_t rx_word,
    input logic     rx_valid,
    input logic     rx_busy,
    input logic     rx_overrun,
    input logic     fifo_full
);

    int unsigned error_count = 0;   // Assertion failures so far

    reset_outputs_low: assert property (@(posedge clk)
        $rose(rst_n) |-> !rx_busy && !rx_valid && !fifo_full)
    else begin
        $error("outputs not low after reset");
        error_count++;
    end

    full_implies_valid: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_full |-> rx_valid)
    else begin
        $error("fifo_full high while rx_valid low");
        error_count++;
    end

    overrun_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        rx_overrun |=> !rx_overrun)
    else begin
        $error("rx_overrun high for two cycles");
        error_count++;
    end

    word_known: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |-> !$isunknown(rx_word))
    else begin
        $error("rx_word has unknown bits while valid");
        error_count++;
    end

endmodule

bind uart_receiver uart_receiver_chk i_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_word   (rx_word),
    .rx_valid  (rx_valid),
    .rx_busy   (rx_busy),
    .rx_overrun(rx_overrun),
    .fifo_full (fifo_full)
);

// ==== tests/uart_receiver_tb.sv ====
`timescale 1ns/1ps

module uart_receiver_tb import uart_pkg::*; ();

    localparam int BIT_CLKS       = OVERSAMPLING * BAUD_DIVIDER;   // Clocks per serial bit
    localparam int NUM_FRAMES     = 40 + 16 + 1 + 11;
    localparam int TIMEOUT_CYCLES = (NUM_FRAMES * 12 + 16) * BIT_CLKS;

    logic     clk;
    logic     rst_n;
    logic     rx_serial;
    logic     rx_read;
    rx_word_t rx_word;
    logic     rx_valid;
    logic     rx_busy;
    logic     rx_overrun;
    logic     fifo_full;

    logic [31:0] lfsr_state = 32'h9e62;
    rx_word_t    exp_q[$];          // Words expected in the FIFO, head first
    int          exp_overruns   = 0;
    int          overrun_seen   = 0;
    int          parity_errs    = 0;
    int          stop_errs      = 0;
    int          cycle_cnt      = 0;

    uart_receiver i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_serial (rx_serial),
        .rx_read   (rx_read),
        .rx_word   (rx_word),
        .rx_valid  (rx_valid),
        .rx_busy   (rx_busy),
        .rx_overrun(rx_overrun),
        .fifo_full (fifo_full)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Overrun is a single cycle pulse, so one negedge sees it once
    always @(negedge clk) begin
        if (rst_n && rx_overrun) begin
            overrun_seen++;
        end
    end

    task abort_run();
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    always @(negedge clk) begin
        if (i_dut.i_chk.error_count != 0) begin
            $display("A checker assertion failed");
            abort_run();
        end
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout, the test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
        abort_run();
    end

    // Galois LFSR, one step per random bit
    function automatic logic next_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b[i] = next_bit();
        end
        return b;
    endfunction

    task automatic check_word(input string name, input rx_word_t got, input rx_word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // Holds one bit for a full bit time, checks busy at its middle
    task automatic drive_bit(input logic b, input logic busy_exp);
        rx_serial <= b;
        repeat (BIT_CLKS / 2) @(posedge clk);
        @(negedge clk);
        check_bit("rx_busy", rx_busy, busy_exp);
        repeat (BIT_CLKS / 2) @(posedge clk);
    endtask

    task automatic send_frame(input logic allow_errors);
        logic [7:0] data;
        logic       bad_parity;
        logic       bad_stop;
        logic       parity;
        rx_word_t   exp;
        data       = rand_byte();
        bad_parity = 1'b0;
        bad_stop   = 1'b0;
        if (allow_errors) begin
            bad_parity = next_bit();
            bad_stop   = next_bit();
        end
        parity = (^data) ^ PARITY_ODD ^ bad_parity;   // Even parity is the XOR of the data

        drive_bit(1'b0, 1'b1);                          // Start
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i], 1'b1);
        end
        if (PARITY_EN) begin
            drive_bit(parity, 1'b1);
        end
        drive_bit(!bad_stop, 1'b1);
        drive_bit(1'b1, 1'b0);                          // Idle bit between frames

        exp.data         = data;
        exp.parity_error = PARITY_EN && bad_parity;
        exp.frame_error  = bad_stop;
        parity_errs     += int'(exp.parity_error);
        stop_errs       += int'(bad_stop);
        if (exp_q.size() < FIFO_DEPTH) begin
            exp_q.push_back(exp);
        end else begin
            exp_overruns++;
        end

        @(negedge clk);
        check_bit("fifo_full", fifo_full, exp_q.size() == FIFO_DEPTH);
        check_bit("rx_valid", rx_valid, exp_q.size() != 0);
        check_count("rx_overrun", overrun_seen, exp_overruns);
        @(posedge clk);
    endtask

    task automatic read_word();
        int       waited;
        rx_word_t exp;
        waited = 0;
        @(negedge clk);
        while (!rx_valid && waited < BIT_CLKS) begin
            @(negedge clk);
            waited++;
        end
        if (!rx_valid) begin
            $display("rx_valid did not rise within one bit time");
            abort_run();
        end
        if (exp_q.size() == 0) begin
            $display("The DUT holds a word that the model does not expect");
            abort_run();
        end
        exp = exp_q.pop_front();
        check_word("rx_word", rx_word, exp);
        @(posedge clk);
        rx_read <= 1'b1;
        @(posedge clk);
        rx_read <= 1'b0;
    endtask

    // Short low pulse, well under half a bit
    task automatic send_glitch();
        rx_serial <= 1'b0;
        repeat (16) @(posedge clk);
        rx_serial <= 1'b1;
        repeat (2 * BIT_CLKS) begin
            @(negedge clk);
            check_bit("rx_valid", rx_valid, 1'b0);
        end
        check_bit("rx_busy", rx_busy, 1'b0);
        @(posedge clk);
    endtask

    initial begin
        rst_n     = 1'b0;
        rx_serial = 1'b1;
        rx_read   = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        repeat (40) begin
            send_frame(1'b0);
            read_word();
        end

        repeat (16) begin
            send_frame(1'b1);
            read_word();
        end
        if (parity_errs == 0 || stop_errs == 0) begin
            $display("The error frames did not cover both parity and stop errors");
            abort_run();
        end

        send_glitch();
        send_frame(1'b0);
        read_word();

        // Fill past the FIFO depth without reading
        repeat (11) begin
            send_frame(1'b0);
        end
        check_count("rx_overrun", overrun_seen, 11 - FIFO_DEPTH);
        repeat (FIFO_DEPTH) begin
            read_word();
        end

        // Read strobe on an empty FIFO
        @(posedge clk);
        rx_read <= 1'b1;
        @(posedge clk);
        rx_read <= 1'b0;
        @(negedge clk);
        check_bit("rx_valid", rx_valid, 1'b0);
        check_bit("fifo_full", fifo_full, 1'b0);

        if (i_dut.i_chk.error_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Checker assertions failed %0d times", i_dut.i_chk.error_count);
            abort_run();
        end
    end

endmodule

// ==== sim.f ====
hdl/uart_pkg.sv
hdl/uart_baud_timer.sv
hdl/uart_rx_framer.sv
hdl/sync_fifo.sv
hdl/uart_receiver.sv
tests/uart_receiver_chk.sv
tests/uart_receiver_tb.sv

// ==== Bender.yml ====
package:
  name: uart_receiver

dependencies: {}

sources:
  # Synthesizable receiver, package first
  - files:
      - hdl/uart_pkg.sv
      - hdl/uart_baud_timer.sv
      - hdl/uart_rx_framer.sv
      - hdl/sync_fifo.sv
      - hdl/uart_receiver.sv

  # Checker and testbench
  - target: simulation
    files:
      - tests/uart_receiver_chk.sv
      - tests/uart_receiver_tb.sv
